//--- hdl/board_pkg.sv
package board_pkg;

    //--------------------
    // board pins

    localparam w_key       = 5;   // last key is reset
    localparam w_sw        = 5;
    localparam w_led       = 6;
    localparam w_gpio      = 32;
    localparam w_gpio_bank = 8;   // four banks of eight

    //--------------------
    // clocking

    localparam default_clk_mhz     = 27;  // board oscillator
    localparam default_slow_clk_hz = 1;

endpackage

//--- hdl/audio_pkg.sv
package audio_pkg;

    //--------------------
    // i2s framing

    localparam w_sample  = 24;  // inmp441 sample width
    localparam sck_div   = 8;   // clk cycles per sck period
    localparam slot_bits = 32;  // sck periods per channel

    //--------------------
    // level meter

    localparam w_gain      = 3;   // gain shift select
    localparam level_shift = 20;  // magnitude to bar level

    //--------------------
    // microphone pins on GPIO_0

    localparam pin_sd  = 4;
    localparam pin_lr  = 5;
    localparam pin_ws  = 6;
    localparam pin_sck = 7;

endpackage

//--- hdl/slow_clk_gen.sv
module slow_clk_gen
# (
    parameter fast_clk_mhz = 27,
              slow_clk_hz  = 1
)
(
    input        clk,
    input        rst,
    output logic slow_clk
);

    localparam int half   = fast_clk_mhz * 1_000_000 / (2 * slow_clk_hz);
    localparam int w_half = half > 1 ? $clog2(half) : 1;

    logic [w_half - 1:0] cnt;  // half period counter

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end
        else if (cnt == w_half'(half - 1))
        begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;  // toggle every half period
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- hdl/inmp441_mic_i2s_receiver.sv
module inmp441_mic_i2s_receiver
(
    input                                     clk,
    input                                     rst,
    output                                    lr,
    output logic                              ws,
    output logic                              sck,
    input                                     sd,
    output logic [audio_pkg::w_sample - 1:0]  value
);

    import audio_pkg::*;

    localparam w_presc   = $clog2(sck_div);
    localparam w_bit     = $clog2(2 * slot_bits);
    localparam first_bit = 1;         // after the one bit i2s delay
    localparam last_bit  = w_sample;  // lsb of the left sample

    logic [w_presc  - 1:0] presc;
    logic [w_bit    - 1:0] bit_cnt;   // sck periods into the frame
    logic [w_bit    - 1:0] bit_next;
    logic [w_sample - 1:0] shift;
    logic                  rise;
    logic                  fall;
    logic                  capture;
    logic                  done;

    assign rise     = presc == w_presc'(sck_div / 2 - 1);
    assign fall     = presc == w_presc'(sck_div - 1);
    assign bit_next = bit_cnt + 1'b1;

    // left slot bits 2 to 25, msb first
    assign capture  = rise
                   && bit_cnt >= w_bit'(first_bit)
                   && bit_cnt <= w_bit'(last_bit);

    assign lr = 1'b0;  // select left channel

    //--------------------
    // sck and ws framing

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            presc   <= '0;
            bit_cnt <= '0;
            sck     <= 1'b0;
            ws      <= 1'b0;
        end
        else if (fall)
        begin
            presc   <= '0;
            bit_cnt <= bit_next;
            sck     <= 1'b0;
            ws      <= bit_next[w_bit - 1];  // high in the right slot
        end
        else
        begin
            presc <= presc + 1'b1;
            if (rise)
                sck <= 1'b1;
        end
    end

    //--------------------
    // sample capture

    always_ff @(posedge clk)
        if (capture)
            shift <= {shift[w_sample - 2:0], sd};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            done  <= 1'b0;
            value <= '0;
        end
        else
        begin
            done <= capture && bit_cnt == w_bit'(last_bit);
            if (done)
                value <= shift;  // full sample in the shifter
        end
    end

endmodule

//--- hdl/lab_top.sv
module lab_top
(
    input                                     clk,
    input                                     slow_clk,
    input                                     rst,
    input        [board_pkg::w_key    - 1:0]  key,
    input        [board_pkg::w_sw     - 1:0]  sw,
    output logic [board_pkg::w_led    - 1:0]  led,
    input        [audio_pkg::w_sample - 1:0]  mic
);

    import board_pkg::*;
    import audio_pkg::*;

    localparam w_wide  = w_sample + (1 << w_gain) - 1;  // room for max gain
    localparam w_level = w_sample - level_shift;

    localparam logic [w_sample - 1:0] max_mag = {1'b0, {(w_sample - 1){1'b1}}};
    localparam logic [w_sample - 1:0] min_neg = {1'b1, {(w_sample - 1){1'b0}}};

    logic [w_sample - 1:0] mic_abs;
    logic [w_wide   - 1:0] wide;
    logic [w_sample - 1:0] gained;
    logic [w_sample - 1:0] mag;       // registered gained magnitude
    logic [w_sample - 1:0] peak;
    logic [w_sample - 1:0] halved;
    logic [w_sample - 1:0] peak_next;
    logic [w_level  - 1:0] level;
    logic [w_led    - 1:0] bar;
    logic                  slow_d;
    logic                  tick;

    //--------------------
    // rectify and gain

    always_comb
    begin
        if (mic == min_neg)
            mic_abs = max_mag;  // no positive twin
        else if (mic[w_sample - 1])
            mic_abs = -mic;
        else
            mic_abs = mic;

        wide = w_wide'(mic_abs) << sw[w_gain - 1:0];

        if (wide > w_wide'(max_mag))
            gained = max_mag;   // clip at full scale
        else
            gained = wide[w_sample - 1:0];
    end

    always_ff @(posedge clk)
        if (rst)
            mag <= '0;
        else
            mag <= gained;

    //--------------------
    // peak hold with decay

    assign tick = slow_clk & ~slow_d;  // slow_clk rising edge

    always_comb
    begin
        halved    = tick ? peak >> 1 : peak;
        peak_next = mag > halved ? mag : halved;
        if (key[0])
            peak_next = '0;     // clear while held
    end

    // Bar length is the top bits of the peak, clamped to the LED count.
    always_comb
    begin
        level = peak_next[w_sample - 1:level_shift];
        for (int i = 0; i < w_led; i++)
            bar[i] = i < level;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            slow_d <= 1'b0;
            peak   <= '0;
            led    <= '0;
        end
        else
        begin
            slow_d <= slow_clk;
            peak   <= peak_next;
            led    <= bar;
        end
    end

endmodule

//--- hdl/board_specific_top.sv
module board_specific_top
# (
    parameter clk_mhz     = board_pkg::default_clk_mhz,
              slow_clk_hz = board_pkg::default_slow_clk_hz
)
(
    input                                  CLK,

    input  [board_pkg::w_key       - 1:0]  KEY,
    input  [board_pkg::w_sw        - 1:0]  SW,

    input                                  UART_RX,
    output                                 UART_TX,

    output [board_pkg::w_led       - 1:0]  LED,

    inout  [board_pkg::w_gpio_bank - 1:0]  GPIO_0,
    inout  [board_pkg::w_gpio_bank - 1:0]  GPIO_1,
    inout  [board_pkg::w_gpio_bank - 1:0]  GPIO_2,
    inout  [board_pkg::w_gpio_bank - 1:0]  GPIO_3
);

    import board_pkg::*;
    import audio_pkg::*;

    wire clk = CLK;

    //--------------------

    localparam w_lab_key = w_key,
               w_lab_sw  = w_sw,
               w_lab_led = w_led;

    wire  [w_lab_key - 1:0] lab_key;
    wire  [w_lab_sw  - 1:0] top_sw;
    wire  [w_lab_led - 1:0] top_led;

    wire                    rst;
    wire                    slow_clk;
    wire  [w_sample  - 1:0] mic;

    //--------------------

    assign rst     = ~KEY[w_key - 1];  // last key, active low on board
    assign lab_key = ~KEY;
    assign top_sw  = ~SW;
    assign LED     = ~top_led;         // leds lit when low

    assign UART_TX = 1'b1;             // line idle

    //--------------------

    slow_clk_gen
    # (
        .fast_clk_mhz ( clk_mhz     ),
        .slow_clk_hz  ( slow_clk_hz )
    )
    i_slow_clk_gen
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .slow_clk ( slow_clk )
    );

    //--------------------

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk   ( clk              ),
        .rst   ( rst              ),
        .lr    ( GPIO_0 [pin_lr]  ),
        .ws    ( GPIO_0 [pin_ws]  ),
        .sck   ( GPIO_0 [pin_sck] ),
        .sd    ( GPIO_0 [pin_sd]  ),
        .value ( mic              )
    );

    //--------------------

    lab_top i_lab_top
    (
        .clk      ( clk      ),
        .slow_clk ( slow_clk ),
        .rst      ( rst      ),
        .key      ( lab_key  ),
        .sw       ( top_sw   ),
        .led      ( top_led  ),
        .mic      ( mic      )
    );

endmodule

//--- testbench/board_top_props.sv
module board_top_props
(
    input clk,
    input rst,
    input sck,
    input ws
);

    int n_fail = 0;  // failed assertion count

    // sck high for 4 cycles, then low for 4
    sck_high: assert property (@(posedge clk) disable iff (rst)
        $rose(sck) |-> sck [*4] ##1 !sck)
        else
        begin
            $error("sck high phase is not 4 cycles");
            n_fail++;
        end

    sck_low: assert property (@(posedge clk) disable iff (rst)
        $fell(sck) |-> !sck [*4] ##1 sck)
        else
        begin
            $error("sck low phase is not 4 cycles");
            n_fail++;
        end

    // ws moves together with a falling sck
    ws_on_fall: assert property (@(posedge clk) disable iff (rst)
        (ws != $past(ws)) |-> $fell(sck))
        else
        begin
            $error("ws changed away from a sck fall");
            n_fail++;
        end

    reset_low: assert property (@(posedge clk)
        rst |=> (!sck && !ws))
        else
        begin
            $error("sck or ws high during reset");
            n_fail++;
        end

endmodule

bind inmp441_mic_i2s_receiver board_top_props props
(
    .clk ( clk ),
    .rst ( rst ),
    .sck ( sck ),
    .ws  ( ws  )
);

//--- testbench/tb_board_top.sv
module tb_board_top;

    import board_pkg::*;
    import audio_pkg::*;

    localparam max_frames = 64;
    localparam frame_len  = sck_div * slot_bits * 2;  // clk cycles per i2s frame
    localparam tick_first = 1001;                     // peak halves one cycle after slow_clk rise
    localparam tick_every = 2000;
    localparam mic_load   = 197;                      // mic update, cycles into the frame

    logic                 clk;
    logic [w_key   - 1:0] KEY;
    logic [w_sw    - 1:0] SW;
    logic                 UART_RX;
    wire                  UART_TX;
    wire  [w_led   - 1:0] LED;
    wire  [w_gpio_bank - 1:0] gpio0;
    wire  [w_gpio_bank - 1:0] gpio1;
    wire  [w_gpio_bank - 1:0] gpio2;
    wire  [w_gpio_bank - 1:0] gpio3;
    logic                 sd_drv;

    wire sck_pin = gpio0[pin_sck];
    wire ws_pin  = gpio0[pin_ws];

    assign gpio0[pin_sd] = sd_drv;

    // frame schedule
    logic [w_sample - 1:0] smp    [max_frames];
    logic [w_gain   - 1:0] gain_f [max_frames];
    logic                  key_f  [max_frames];
    int                    test_of[max_frames];
    int                    n_frames;
    string                 names  [5];
    int                    checks [5];
    int                    errors [5];
    int                    checked;
    int                    cyc;
    int                    limit;
    logic [31:0]           seed;

    // reference state
    logic [w_sample - 1:0] m_mic;
    logic [w_sample - 1:0] m_mag;
    logic [w_sample - 1:0] m_peak;
    logic [w_led    - 1:0] exp_led;

    board_specific_top
    # (
        .clk_mhz     ( 1   ),
        .slow_clk_hz ( 500 )
    )
    dut
    (
        .CLK     ( clk     ),
        .KEY     ( KEY     ),
        .SW      ( SW      ),
        .UART_RX ( UART_RX ),
        .UART_TX ( UART_TX ),
        .LED     ( LED     ),
        .GPIO_0  ( gpio0   ),
        .GPIO_1  ( gpio1   ),
        .GPIO_2  ( gpio2   ),
        .GPIO_3  ( gpio3   )
    );

    // --------------------
    // helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // magnitude with gain, both steps clipped at full scale
    function automatic logic [w_sample - 1:0] gained_mag(input logic [w_sample - 1:0] s,
                                                        input int g);
        longint full;
        longint v;
        full = (longint'(1) << (w_sample - 1)) - 1;
        v    = longint'($signed(s));
        if (v < 0)
            v = -v;
        if (v > full)
            v = full;
        v = v << g;
        if (v > full)
            v = full;
        return v[w_sample - 1:0];
    endfunction

    function automatic logic [w_led - 1:0] bar_of(input logic [w_sample - 1:0] p);
        int n;
        n = p >> level_shift;
        if (n > w_led)
            n = w_led;
        return (1 << n) - 1;
    endfunction

    task automatic add_frame(input logic [w_sample - 1:0] s, input int g, input logic k,
                             input int t);
        smp[n_frames]     = s;
        gain_f[n_frames]  = g;
        key_f[n_frames]   = k;
        test_of[n_frames] = t;
        n_frames++;
    endtask

    task automatic expect_value(input string name, input logic [w_led - 1:0] got,
                                input logic [w_led - 1:0] want, input int t);
        assert (got === want)
        else
        begin
            $display("error t=%0t %s expected %0b got %0b", $time, name, want, got);
            errors[t]++;
        end
        checks[t]++;
    endtask

    task automatic check_frame();
        int t;
        t = test_of[checked];
        expect_value("LED", LED, ~exp_led, t);
        checked++;
        if (checked == n_frames || test_of[checked] != t)
            $display("test %s done: %0d checks, %0d errors", names[t], checks[t], errors[t]);
    endtask

    // --------------------
    // clock and timeout

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    initial
    begin
        wait (limit > 0 && cyc > limit);
        $display("timeout: only %0d of %0d frames checked after %0d cycles",
                 checked, n_frames, cyc);
        $display("Regression failed");
        $finish;
    end

    // --------------------
    // reference model, one step per clk edge

    initial
    begin : model
        logic [w_sample - 1:0] halved;
        logic [w_sample - 1:0] pn;
        logic [w_sample - 1:0] mag_new;
        logic [w_gain   - 1:0] gain;
        int                    k;
        forever
        begin
            @(posedge clk);
            if (KEY[w_key - 1] !== 1'b1)
            begin
                cyc     = 0;
                m_mic   = '0;
                m_mag   = '0;
                m_peak  = '0;
                exp_led = '0;
            end
            else
            begin
                cyc++;
                gain    = ~SW[w_gain - 1:0];  // switches are active low
                mag_new = gained_mag(m_mic, gain);
                halved  = m_peak;
                if (cyc >= tick_first && (cyc - tick_first) % tick_every == 0)
                    halved = m_peak >> 1;  // slow tick
                pn = m_mag > halved ? m_mag : halved;
                if (~KEY[0])
                    pn = '0;
                m_peak  = pn;
                exp_led = bar_of(pn);
                m_mag   = mag_new;
                if (cyc >= mic_load && (cyc - mic_load) % frame_len == 0)
                begin
                    k     = (cyc - mic_load) / frame_len;
                    m_mic = k < n_frames ? smp[k] : '0;
                end
            end
        end
    end

    // --------------------
    // microphone model

    initial
    begin : mic_model
        int                    idx;
        int                    frame;
        logic                  ws_prev;
        logic [w_sample - 1:0] s;
        idx     = 0;
        frame   = 0;
        ws_prev = 1'b0;
        wait (KEY[w_key - 1] === 1'b1);
        forever
        begin
            @(negedge sck_pin);
            #1;
            if (ws_pin == 1'b0 && ws_prev == 1'b1)
            begin
                idx = 0;  // new left slot
                frame++;
            end
            else
                idx++;
            ws_prev = ws_pin;
            s = frame < n_frames ? smp[frame] : '0;
            if (idx >= 1 && idx <= w_sample)
                sd_drv = s[w_sample - idx];  // msb first after the delay bit
            else
                sd_drv = 1'b0;
        end
    end

    // --------------------
    // compare at each ws rise

    initial
    begin : compare
        logic ws_last;
        ws_last = 1'b0;
        forever
        begin
            @(negedge clk);
            if (KEY[w_key - 1] === 1'b1 && ws_pin === 1'b1 && ws_last === 1'b0
                && checked < n_frames)
                check_frame();
            ws_last = ws_pin;
        end
    end

    // --------------------
    // main sequence

    initial
    begin : main
        int total_err;
        int total_chk;
        logic [31:0] r;
        KEY      = 5'b01111;  // reset key pressed
        SW       = '1;
        UART_RX  = 1'b1;
        sd_drv   = 1'b0;
        n_frames = 0;
        checked  = 0;
        cyc      = 0;
        limit    = 0;
        seed     = 32'hc2e46266;
        names    = '{"reset", "signs", "gain", "peak_hold", "clear_decay"};
        foreach (checks[i])
        begin
            checks[i] = 0;
            errors[i] = 0;
        end

        add_frame(24'h100000, 0, 1'b0, 1);
        add_frame(24'he00000, 0, 1'b0, 1);
        add_frame(24'hd00000, 0, 1'b0, 1);
        add_frame(24'h7fffff, 0, 1'b0, 1);
        add_frame(24'h800000, 0, 1'b0, 1);  // most negative
        add_frame(24'hffffff, 0, 1'b0, 1);
        add_frame(24'h000000, 0, 1'b1, 2);
        for (int g = 0; g < 8; g++)
            add_frame(24'h080000, g, 1'b0, 2);
        for (int i = 0; i < 6; i++)
        begin
            seed = lcg_next(seed);
            r    = seed;
            add_frame(24'($signed(r[31:8]) >>> r[2:0]), int'(r[5:3]), 1'b0, 2);
        end
        add_frame(24'h000000, 0, 1'b1, 3);
        add_frame(24'h600000, 0, 1'b0, 3);
        for (int i = 0; i < 5; i++)
            add_frame(24'h100000, 0, 1'b0, 3);
        add_frame(24'h000000, 0, 1'b1, 4);
        add_frame(24'h400000, 0, 1'b0, 4);
        add_frame(24'h000000, 0, 1'b1, 4);
        add_frame(24'hc00000, 0, 1'b0, 4);
        for (int i = 0; i < 14; i++)
            add_frame(24'h000000, 0, 1'b0, 4);  // silence over several ticks
        limit = (n_frames + 4) * frame_len;

        repeat (2)
        begin
            @(posedge clk);
            #1;
        end
        expect_value("LED", LED, '1, 0);
        expect_value("sck", sck_pin, 1'b0, 0);
        expect_value("ws", ws_pin, 1'b0, 0);
        expect_value("UART_TX", UART_TX, 1'b1, 0);
        expect_value("lr", gpio0[pin_lr], 1'b0, 0);
        KEY[w_key - 1] = 1'b1;  // release reset

        for (int k = 0; k < n_frames; k++)
        begin
            while (cyc != frame_len * k + 1)
            begin
                @(posedge clk);
                #1;
            end
            if (k == 0)
            begin
                expect_value("LED", LED, '1, 0);
                $display("test %s done: %0d checks, %0d errors", names[0], checks[0],
                         errors[0]);
            end
            SW     = ~{2'b00, gain_f[k]};
            KEY[0] = ~key_f[k];
        end

        wait (checked == n_frames);
        total_err = dut.i_microphone.props.n_fail;
        total_chk = 0;
        foreach (errors[i])
        begin
            total_err += errors[i];
            total_chk += checks[i];
        end
        $display("summary: %0d checks, %0d errors (%0d from assertions)", total_chk,
                 total_err, dut.i_microphone.props.n_fail);
        if (total_err == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- src.f
hdl/board_pkg.sv
hdl/audio_pkg.sv
hdl/slow_clk_gen.sv
hdl/inmp441_mic_i2s_receiver.sv
hdl/lab_top.sv
hdl/board_specific_top.sv
testbench/board_top_props.sv
testbench/tb_board_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_board_top
BUILD_DIR ?= build
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' src.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): src.f $(SRCS)
	$(VERILATOR) --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f src.f \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
